//--- dv/scan_stream_tb.sv
// testbench for the streaming prefix-scan unit
// sends requests against upstream credits and returns downstream credits
// every result is checked against a bit-serial reference of the scan rule
`timescale 1ns/10ps

module scan_stream_tb
#(
   parameter int fifo_els_p    = 4,
   parameter int out_credits_p = 2
);

   import scan_pkg::*;

   localparam int n_xor_c      = 8;
   localparam int n_andor_c    = 32;
   localparam int n_random_c   = 300;
   localparam int n_bp_c       = 10;
   localparam int total_reqs_c = n_xor_c + n_andor_c + n_random_c + n_bp_c;
   localparam int limit_c      = total_reqs_c * 40 + 1000;

   // all ones, single bits and a few gray codes
   localparam logic [word_width_c-1:0] xor_words_c [n_xor_c] =
      '{16'hffff, 16'h8000, 16'h0001, 16'h0100, 16'h0000, 16'h0f0f, 16'h5555, 16'hc3a1};
   // top bit or bottom bit alone decides several of these
   localparam logic [word_width_c-1:0] andor_words_c [8] =
      '{16'h8000, 16'h7fff, 16'h0001, 16'hfffe, 16'hffff, 16'h0000, 16'h00f0, 16'ha5a5};

   logic      clk;
   logic      reset;
   logic      in_valid;
   scan_req_s in_req;
   logic      in_credit;
   logic      out_valid;
   scan_res_s out_res;
   logic      out_credit = 1'b0;

   scan_res_s              expected_q [$];
   string                  name_q [$];
   int                     res_errors = 0;
   int                     count_errors = 0;
   int                     sent_count = 0;
   int                     received_count = 0;
   int                     up_credits;
   int                     returned_total = 0;
   int                     owed = 0;
   logic                   hold_credits = 1'b0;
   logic [tag_width_c-1:0] next_tag = '0;

   tb_clock_gen #(.period_p(10), .reset_cycles_p(4)) clock_i (.clk(clk), .reset(reset));

   scan_stream_top #(.fifo_els_p(fifo_els_p), .out_credits_p(out_credits_p)) dut_i
   (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_req     (in_req),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_res    (out_res),
      .out_credit (out_credit)
   );

   // expected result straight from the scan rule, one output bit at a time
   function automatic scan_res_s ref_scan(input scan_req_s req);
      scan_res_s res;
      logic      acc;
      int        j;
      for (int k = 0; k < word_width_c; k++)
      begin
         j = req.lo_to_hi ? 0 : word_width_c - 1;
         acc = req.data[j];
         // walk from the first bit of the scan toward bit k
         while (j != k)
         begin
            j = req.lo_to_hi ? j + 1 : j - 1;
            case (req.op)
               op_and:  acc = acc & req.data[j];
               op_or:   acc = acc | req.data[j];
               default: acc = acc ^ req.data[j];
            endcase
         end
         res.result[k] = acc;
      end
      res.op  = req.op;
      res.tag = req.tag;
      return res;
   endfunction

   task automatic check_res(input string name, input scan_res_s exp, input scan_res_s act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected result=%h op=%0d tag=%h, actual result=%h op=%0d tag=%h",
                  name, exp.result, exp.op, exp.tag, act.result, act.op, act.tag);
         res_errors++;
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp)
      begin
         $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
         count_errors++;
      end
   endtask

   // one driver cycle, picking up any in_credit pulse
   task automatic step_cycle();
      @(negedge clk);
      if (in_credit === 1'b1)
      begin
         up_credits++;
         returned_total++;
      end
   endtask

   task automatic idle_cycle();
      in_valid = 1'b0;
      step_cycle();
   endtask

   task automatic send_req(input string name, input logic [word_width_c-1:0] data,
                           input scan_op_e op, input logic lo_to_hi);
      scan_req_s req;
      req.data     = data;
      req.op       = op;
      req.lo_to_hi = lo_to_hi;
      req.tag      = next_tag;
      // no credit, no request
      while (up_credits == 0)
         idle_cycle();
      in_valid = 1'b1;
      in_req   = req;
      up_credits--;
      expected_q.push_back(ref_scan(req));
      name_q.push_back(name);
      sent_count++;
      next_tag = next_tag + 1'b1;
      step_cycle();
   endtask

   // every upstream credit back means every item has been popped
   // the last out_valid and the downstream credits settle in the idle cycles
   task automatic wait_drain();
      while (up_credits != fifo_els_p)
         idle_cycle();
      repeat (4) idle_cycle();
   endtask

   // downstream side returns a credit one cycle after each out_valid unless held
   always @(negedge clk)
   begin
      if (!hold_credits && owed > 0)
      begin
         out_credit = 1'b1;
         owed--;
      end
      else
         out_credit = 1'b0;
      if (out_valid === 1'b1)
         owed++;
   end

   always @(negedge clk)
   begin
      if (out_valid === 1'b1)
      begin
         if (expected_q.size() == 0)
         begin
            $display("result with tag %h came out with no request outstanding", out_res.tag);
            res_errors++;
         end
         else
            check_res(name_q.pop_front(), expected_q.pop_front(), out_res);
         received_count <= received_count + 1;
      end
   end

   initial
   begin
      repeat (limit_c) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", limit_c);
      $display("Finished with errors");
      $finish;
   end

   initial
   begin
      int         bad;
      int         bp_base;
      int         bp_sent;
      int         snap;
      logic [1:0] op_bits;
      scan_req_s  probe;
      scan_res_s  probe_res;
      in_valid   = 1'b0;
      in_req     = '0;
      up_credits = fifo_els_p;
      void'($urandom(32'h416d0687));

      // outputs quiet through reset and while idle
      bad = 0;
      @(posedge clk);
      while (reset !== 1'b0)
      begin
         step_cycle();
         if (out_valid !== 1'b0 || in_credit !== 1'b0)
            bad++;
      end
      repeat (6)
      begin
         idle_cycle();
         if (out_valid !== 1'b0 || in_credit !== 1'b0)
            bad++;
      end
      check_count("reset outputs", 0, bad);
      check_count("reset results", 0, received_count);

      // xor from the top bit down is the gray to binary conversion
      probe = '0;
      probe.data = '1;
      probe_res = ref_scan(probe);
      check_count("ref_scan xor of all ones", 'haaaa, int'(probe_res.result));
      for (int w = 0; w < n_xor_c; w++)
         send_req("xor high to low", xor_words_c[w], op_xor, 1'b0);
      wait_drain();

      for (int o = 0; o < 2; o++)
         for (int d = 0; d < 2; d++)
            for (int w = 0; w < 8; w++)
               send_req("and or scans", andor_words_c[w], (o == 0) ? op_and : op_or, d[0]);
      wait_drain();

      // back to back as far as credits allow
      for (int n = 0; n < n_random_c; n++)
      begin
         op_bits = 2'($urandom_range(0, 2));
         send_req("random stream", word_width_c'($urandom), scan_op_e'(op_bits),
                  1'($urandom_range(0, 1)));
      end
      wait_drain();

      // with downstream credits withheld the FIFO fills and upstream stalls
      hold_credits <= 1'b1;
      bp_base = received_count;
      bp_sent = 0;
      snap    = 0;
      for (int c = 0; c < 24; c++)
      begin
         if (c == 12)
            snap = returned_total;
         if (up_credits > 0 && bp_sent < n_bp_c)
         begin
            send_req("backpressure", word_width_c'($urandom), op_xor, 1'b1);
            bp_sent++;
         end
         else
            idle_cycle();
      end
      check_count("backpressure results out", out_credits_p, received_count - bp_base);
      check_count("backpressure items accepted", fifo_els_p + out_credits_p, bp_sent);
      check_count("backpressure in_credit while stalled", 0, returned_total - snap);
      check_count("backpressure upstream credits", 0, up_credits);
      hold_credits <= 1'b0;
      while (bp_sent < n_bp_c)
      begin
         send_req("backpressure", word_width_c'($urandom), op_and, 1'b0);
         bp_sent++;
      end
      wait_drain();
      check_count("total results", sent_count, received_count);

      $display("result errors: %0d, count errors: %0d, results checked: %0d of %0d",
               res_errors, count_errors, received_count, sent_count);
      if (res_errors == 0 && count_errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

//--- dv/tb_clock_gen.sv
// clock and reset source for the testbench
// free-running clock, synchronous reset held for reset_cycles_p rising edges
`timescale 1ns/10ps

module tb_clock_gen
#(
   parameter int period_p       = 10,
   parameter int reset_cycles_p = 4
)
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #(period_p / 2) clk = ~clk;
   end

   // released on a falling edge, away from the sampling edge
   initial
   begin
      reset = 1'b1;
      repeat (reset_cycles_p) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

//--- hw/credit_fifo.sv
// circular FIFO between producer and consumer
// depth els_p is also the upstream credit budget
// head read combinationally, one credit pulse per pop, a cycle later
// writer never overruns since upstream holds at most els_p credits
`timescale 1ns/10ps

module credit_fifo
#(
   parameter int els_p = 4
)
(
   input  logic                clk,
   input  logic                reset,
   input  logic                wr_valid,
   input  scan_pkg::scan_res_s wr_data,
   output logic                rd_valid,
   output scan_pkg::scan_res_s rd_data,
   input  logic                rd_pop,
   output logic                credit
);

   import scan_pkg::*;

   // at least one pointer bit even for a single entry
   localparam int ptr_width_lp   = (els_p > 1) ? $clog2(els_p) : 1;
   localparam int count_width_lp = $clog2(els_p + 1);
   localparam logic [ptr_width_lp-1:0] last_lp = ptr_width_lp'(els_p - 1);

   scan_res_s mem [els_p];

   logic [ptr_width_lp-1:0]   wr_ptr;
   logic [ptr_width_lp-1:0]   rd_ptr;
   logic [count_width_lp-1:0] count;

   // head entry visible the cycle after its write
   assign rd_valid = (count != '0);
   assign rd_data  = mem[rd_ptr];

   // entry storage
   always_ff @(posedge clk)
   begin
      if (wr_valid)
         mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end
      else
      begin
         // pointers wrap at els_p, not just at a power of two
         if (wr_valid)
            wr_ptr <= (wr_ptr == last_lp) ? '0 : wr_ptr + 1'b1;
         if (rd_pop)
            rd_ptr <= (rd_ptr == last_lp) ? '0 : rd_ptr + 1'b1;

         case ({wr_valid, rd_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            // push and pop together leave occupancy alone
            default: count <= count;
         endcase

         // freed slot goes back upstream as a credit
         credit <= rd_pop;
      end
   end

endmodule

//--- hw/credit_out_port.sv
// consumer port toward downstream
// holds the downstream credit count, starting at credits_p
// pops the FIFO head while credit remains, result registered out
`timescale 1ns/10ps

module credit_out_port
#(
   parameter int credits_p = 2
)
(
   input  logic                clk,
   input  logic                reset,
   input  logic                head_valid,
   input  scan_pkg::scan_res_s head,
   output logic                pop,
   input  logic                out_credit,
   output logic                out_valid,
   output scan_pkg::scan_res_s out_res
);

   import scan_pkg::*;

   localparam int count_width_lp = $clog2(credits_p + 1);

   logic [count_width_lp-1:0] credit_count;

   // send only against a held credit
   assign pop = head_valid && (credit_count != '0);

   // credit spent at the pop, each pop gives exactly one out_valid
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         credit_count <= count_width_lp'(credits_p);
         out_valid    <= 1'b0;
      end
      else
      begin
         case ({pop, out_credit})
            2'b10:   credit_count <= credit_count - 1'b1;
            2'b01:   credit_count <= credit_count + 1'b1;
            // send and return in one cycle cancel out
            default: credit_count <= credit_count;
         endcase
         out_valid <= pop;
      end
   end

   // payload register, qualified by out_valid
   always_ff @(posedge clk)
   begin
      if (pop)
         out_res <= head;
   end

endmodule

//--- hw/prefix_scan.sv
// Kogge-Stone prefix tree, scanning from the top bit down
// one operator per instance, fixed by op_p
// output bit k holds the operator applied over bits width_p-1 .. k
// purely combinational
`timescale 1ns/10ps

module prefix_scan
#(
   parameter int                width_p = 16,
   parameter scan_pkg::scan_op_e op_p   = scan_pkg::op_xor
)
(
   input  logic [width_p-1:0] i,
   output logic [width_p-1:0] o
);

   import scan_pkg::*;

   // number of doubling rows
   localparam int rows_lp = $clog2(width_p);

   // row 0 is the raw input, row rows_lp the full scan
   logic [rows_lp:0][width_p-1:0] t;

   // identity of the operator, shifted in at the top
   // ones for and, zeros for xor and or
   localparam logic [width_p-1:0] fill_lp = (op_p == op_and) ? '1 : '0;

   assign t[0] = i;

   // worked example, xor over 8 ones
   //   row 1: 1111_1111 ^ 0111_1111 -> 1000_0000
   //   row 2: 1000_0000 ^ 0010_0000 -> 1010_0000
   //   row 3: 1010_0000 ^ 0000_1010 -> 1010_1010
   // i.e. the prefix parity from the top bit

   for (genvar j = 0; j < rows_lp; j++)
   begin : row
      logic [width_p-1:0] shifted;

      // shift down by 2**j, vacated top bits take the identity
      assign shifted = width_p'({fill_lp, t[j]} >> (1 << j));

      // top bit only ever meets the identity, so it passes through
      if (op_p == op_and)
      begin : g_and
         assign t[j+1] = t[j] & shifted;
      end
      else if (op_p == op_or)
      begin : g_or
         assign t[j+1] = t[j] | shifted;
      end
      else
      begin : g_xor
         assign t[j+1] = t[j] ^ shifted;
      end
   end

   assign o = t[rows_lp];

endmodule

//--- hw/scan_pkg.sv
// shared types for the streaming prefix-scan unit
// request and result words as carried between the stages
// imported by every module that handles a request or a result
package scan_pkg;

   // data word carried by each request
   localparam int word_width_c = 16;

   // request tag, returned untouched with the result
   localparam int tag_width_c = 8;

   // scan operator
   // 2'b11 is unused and treated as xor by the producer
   typedef enum logic [1:0]
   {
      op_xor = 2'b00,
      op_and = 2'b01,
      op_or  = 2'b10
   } scan_op_e;

   // request from upstream, 27 bits
   typedef struct packed
   {
      logic [word_width_c-1:0] data;
      scan_op_e                op;
      // set for a scan from bit 0 upward
      logic                    lo_to_hi;
      logic [tag_width_c-1:0]  tag;
   } scan_req_s;

   // result toward downstream, 26 bits
   // op travels along so the receiver knows what was done
   typedef struct packed
   {
      logic [word_width_c-1:0] result;
      scan_op_e                op;
      logic [tag_width_c-1:0]  tag;
   } scan_res_s;

endpackage

//--- hw/scan_stage.sv
// producer stage of the scan stream
// runs xor, and and or trees side by side, picks one by op
// reverses the word around the trees for a low-to-high scan
// result, op and tag registered, valid one cycle after in_valid
`timescale 1ns/10ps

module scan_stage
(
   input  logic                clk,
   input  logic                reset,
   input  logic                in_valid,
   input  scan_pkg::scan_req_s in_req,
   output logic                stage_valid,
   output scan_pkg::scan_res_s stage_res
);

   import scan_pkg::*;

   // bit k moves to bit word_width_c-1-k
   function automatic logic [word_width_c-1:0] reverse_bits(input logic [word_width_c-1:0] v);
      logic [word_width_c-1:0] r;
      for (int k = 0; k < word_width_c; k++)
      begin
         r[k] = v[word_width_c-1-k];
      end
      return r;
   endfunction

   logic [word_width_c-1:0] tree_in;
   logic [word_width_c-1:0] xor_out;
   logic [word_width_c-1:0] and_out;
   logic [word_width_c-1:0] or_out;
   logic [word_width_c-1:0] sel_out;
   logic [word_width_c-1:0] scan_out;

   // trees only scan high to low
   // flipped in and out, this gives bit k = f(bits 0..k)
   assign tree_in = in_req.lo_to_hi ? reverse_bits(in_req.data) : in_req.data;

   prefix_scan #(.width_p(word_width_c), .op_p(op_xor)) xor_scan_i (.i(tree_in), .o(xor_out));
   prefix_scan #(.width_p(word_width_c), .op_p(op_and)) and_scan_i (.i(tree_in), .o(and_out));
   prefix_scan #(.width_p(word_width_c), .op_p(op_or))  or_scan_i  (.i(tree_in), .o(or_out));

   always_comb
   begin
      case (in_req.op)
         op_and:  sel_out = and_out;
         op_or:   sel_out = or_out;
         // xor, and the unused code
         default: sel_out = xor_out;
      endcase
   end

   assign scan_out = in_req.lo_to_hi ? reverse_bits(sel_out) : sel_out;

   // one item in flight, valid follows in_valid by a cycle
   always_ff @(posedge clk)
   begin
      if (reset)
         stage_valid <= 1'b0;
      else
         stage_valid <= in_valid;
   end

   always_ff @(posedge clk)
   begin
      if (in_valid)
      begin
         stage_res.result <= scan_out;
         stage_res.op     <= in_req.op;
         stage_res.tag    <= in_req.tag;
      end
   end

endmodule

//--- hw/scan_stream_top.sv
// top of the streaming prefix-scan unit
// producer -> credit FIFO -> credit output port
// upstream starts with fifo_els_p credits, downstream grants out_credits_p
// in_valid to out_valid is three cycles at least
`timescale 1ns/10ps

module scan_stream_top
#(
   parameter int fifo_els_p    = 4,
   parameter int out_credits_p = 2
)
(
   input  logic                clk,
   input  logic                reset,
   input  logic                in_valid,
   input  scan_pkg::scan_req_s in_req,
   output logic                in_credit,
   output logic                out_valid,
   output scan_pkg::scan_res_s out_res,
   input  logic                out_credit
);

   import scan_pkg::*;

   logic      stage_valid;
   scan_res_s stage_res;
   logic      fifo_valid;
   scan_res_s fifo_res;
   logic      fifo_pop;

   // producer, no stall needed since upstream credits cover the FIFO
   scan_stage stage_i
   (
      .clk         (clk),
      .reset       (reset),
      .in_valid    (in_valid),
      .in_req      (in_req),
      .stage_valid (stage_valid),
      .stage_res   (stage_res)
   );

   // buffer, returns in_credit per pop
   credit_fifo #(.els_p(fifo_els_p)) fifo_i
   (
      .clk      (clk),
      .reset    (reset),
      .wr_valid (stage_valid),
      .wr_data  (stage_res),
      .rd_valid (fifo_valid),
      .rd_data  (fifo_res),
      .rd_pop   (fifo_pop),
      .credit   (in_credit)
   );

   credit_out_port #(.credits_p(out_credits_p)) out_port_i
   (
      .clk        (clk),
      .reset      (reset),
      .head_valid (fifo_valid),
      .head       (fifo_res),
      .pop        (fifo_pop),
      .out_credit (out_credit),
      .out_valid  (out_valid),
      .out_res    (out_res)
   );

endmodule

//--- list.f
hw/scan_pkg.sv
hw/prefix_scan.sv
hw/scan_stage.sv
hw/credit_fifo.sv
hw/credit_out_port.sv
hw/scan_stream_top.sv
dv/tb_clock_gen.sv
dv/scan_stream_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# exit status is non-zero on a build error, a simulator error or a failing test

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -j 0 --top-module scan_stream_tb -f list.f -o sim_exe
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_exe > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Finished with errors" "$log"; then
   exit 1
fi
exit 0
